// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // cache geometry
    localparam int LEN_LINE = 6;
    localparam int LEN_INDEX = 6;
    localparam int NR_WAYS = 2;
    localparam int NR_WORDS = 16;
    localparam int LEN_TAG = 20;

    // joint TLB size
    localparam int NR_TLB = 8;

    // first fetch lands in kseg1, so no TLB or cache is needed to boot
    localparam logic [31:0] BOOT_PC = 32'hbfc00000;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] inst_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0] tlb_idx_t;

    // one even/odd page pair
    typedef struct packed {
        vpn2_t vpn2;
        pfn_t pfn0;
        logic c0;
        logic v0;
        pfn_t pfn1;
        logic c1;
        logic v1;
    } tlb_entry;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_TLB_REFILL,
        EXC_TLB_INVALID
    } fetch_exc_t;

endpackage

// ==== src/bram_dp.sv ====
module bram_dp #(
    parameter int LEN_DATA = 64,
    parameter int LEN_ADDR = 9,
    parameter int NR_BE = 8
) (
    input  logic                clk,
    input  logic [LEN_ADDR-1:0] addra,
    input  logic [LEN_DATA-1:0] dina,
    input  logic [NR_BE-1:0]    wea,
    input  logic [LEN_ADDR-1:0] addrb,
    output logic [LEN_DATA-1:0] doutb
);

    logic [LEN_DATA-1:0] mem [1 << LEN_ADDR];

    // port a writes, one enable per lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < NR_BE; b++) begin
            if (wea[b]) begin
                mem[addra][b * (LEN_DATA / NR_BE) +: LEN_DATA / NR_BE] <=
                    dina[b * (LEN_DATA / NR_BE) +: LEN_DATA / NR_BE];
            end
        end
    end

    // port b registered read
    always_ff @(posedge clk) begin
        doutb <= mem[addrb];
    end

endmodule

// ==== src/jtlb.sv ====
module jtlb (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  fetch_pkg::tlb_idx_t  windex,
    input  fetch_pkg::tlb_entry  wentry,
    input  fetch_pkg::vpn2_t     vpn2,
    output logic                 found,
    output fetch_pkg::tlb_entry  entry
);

    fetch_pkg::tlb_entry entries [fetch_pkg::NR_TLB];
    logic [fetch_pkg::NR_TLB-1:0] present;

    always_ff @(posedge clk) begin
        if (rst) begin
            present <= '0;
        end else if (we) begin
            present[windex] <= 1'b1;
        end
    end

    // entry payload, valid only where present is set
    always_ff @(posedge clk) begin
        if (we) begin
            entries[windex] <= wentry;
        end
    end

    // scan downwards so the lowest matching index wins
    always_comb begin
        found = 1'b0;
        entry = '0;
        for (int k = fetch_pkg::NR_TLB - 1; k >= 0; k--) begin
            if (present[k] && entries[k].vpn2 == vpn2) begin
                found = 1'b1;
                entry = entries[k];
            end
        end
    end

endmodule

// ==== src/fetch_pc.sv ====
module fetch_pc (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               istall,
    input  logic               inst_ok0,
    input  logic               inst_ok1,
    input  logic               redirect,
    input  fetch_pkg::vaddr_t  redirect_pc,
    output logic               inst_en,
    output fetch_pkg::vaddr_t  inst_va,
    output fetch_pkg::vaddr_t  inst_va_next
);

    logic accept;

    // fetch taken by the pipeline this cycle
    assign accept = inst_ok0 && !istall && !stall;

    // value the pc holds next cycle, also the cache read-ahead address
    always_comb begin
        if (redirect) begin
            inst_va_next = redirect_pc;
        end else if (accept) begin
            inst_va_next = inst_va + (inst_ok1 ? 32'd8 : 32'd4);
        end else begin
            inst_va_next = inst_va;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_va <= fetch_pkg::BOOT_PC;
            inst_en <= 1'b0;
        end else begin
            inst_va <= inst_va_next;
            inst_en <= 1'b1;
        end
    end

endmodule

// ==== src/i_cache.sv ====
module i_cache (
    input  logic                 clk,
    input  logic                 rst,
    // fetch side
    input  logic                 inst_en,
    input  fetch_pkg::vaddr_t    inst_va,
    input  fetch_pkg::vaddr_t    inst_va_next,
    output fetch_pkg::inst_t     inst_rdata0,
    output fetch_pkg::inst_t     inst_rdata1,
    output logic                 inst_ok0,
    output logic                 inst_ok1,
    output logic                 inst_tlb_refill,
    output logic                 inst_tlb_invalid,
    input  logic                 stallF,
    output logic                 istall,
    input  logic                 fence_i,
    input  fetch_pkg::vaddr_t    fence_addr,
    input  logic                 fence_tlb,
    // joint TLB lookup
    output fetch_pkg::vpn2_t     itlb_vpn2,
    input  logic                 itlb_found,
    input  fetch_pkg::tlb_entry  itlb_entry,
    // AXI read channels
    output fetch_pkg::paddr_t    araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  logic                 arready,
    input  logic [31:0]          rdata,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready
);

    typedef enum logic [2:0] {
        IDLE,
        TLB_FILL,
        UNCACHED,
        REFILL,
        SAVE_RESULT
    } state_t;

    state_t state;

    // per-set metadata, lru points at the way to replace next
    logic [fetch_pkg::NR_WAYS-1:0] meta_valid [1 << fetch_pkg::LEN_INDEX];
    logic meta_lru [1 << fetch_pkg::LEN_INDEX];

    // one-entry L1 iTLB
    logic itlb_valid;
    logic [19:0] itlb_vpn;
    fetch_pkg::pfn_t itlb_ppn;
    logic itlb_uncached;

    logic direct_mapped;
    logic uncached;
    logic translation_ok;
    fetch_pkg::pfn_t inst_tag;
    fetch_pkg::paddr_t inst_pa;

    logic [fetch_pkg::LEN_INDEX-1:0] va_line;
    logic [fetch_pkg::LEN_INDEX-1:0] fence_line;
    logic [fetch_pkg::LEN_INDEX-1:0] refill_line;
    logic [fetch_pkg::LEN_TAG-1:0] refill_tag;
    logic refill_way;
    logic [fetch_pkg::LEN_LINE-3:0] axi_cnt;
    logic beat;

    logic [63:0] cache_data [fetch_pkg::NR_WAYS];
    logic [fetch_pkg::LEN_TAG-1:0] cache_tag [fetch_pkg::NR_WAYS];
    logic [7:0] data_wea [fetch_pkg::NR_WAYS];
    logic tag_wea [fetch_pkg::NR_WAYS];
    logic [fetch_pkg::NR_WAYS-1:0] hit_vec;
    logic cache_hit;
    logic hit_ok;
    logic hit_way;
    fetch_pkg::inst_t cache_inst0;
    fetch_pkg::inst_t cache_inst1;

    // request held while the FSM is away from idle
    fetch_pkg::vaddr_t req_va;
    fetch_pkg::inst_t saved_inst0;
    logic saved_ok0;
    logic saved_match;
    logic fence_ok;

    // kseg0 and kseg1 bypass the TLB, kseg1 is uncached
    assign direct_mapped = inst_va[31:30] == 2'b10;
    assign uncached = direct_mapped ? inst_va[29] : itlb_uncached;
    assign inst_tag = direct_mapped ? {3'b000, inst_va[28:12]} : itlb_ppn;
    assign inst_pa = {inst_tag, inst_va[11:0]};
    assign translation_ok = direct_mapped || (itlb_valid && itlb_vpn == inst_va[31:12]);

    assign va_line = inst_va[fetch_pkg::LEN_LINE +: fetch_pkg::LEN_INDEX];
    assign fence_line = fence_addr[fetch_pkg::LEN_LINE +: fetch_pkg::LEN_INDEX];

    // refill data beat lands in the ram this cycle
    assign beat = state == REFILL && !arvalid && rvalid && rready;

    for (genvar w = 0; w < fetch_pkg::NR_WAYS; w++) begin : g_way
        assign data_wea[w] = (beat && refill_way == w) ? (axi_cnt[0] ? 8'hf0 : 8'h0f) : 8'h00;
        assign tag_wea[w] = beat && rlast && refill_way == w;

        bram_dp #(
            .LEN_DATA (64),
            .LEN_ADDR (fetch_pkg::LEN_INDEX + fetch_pkg::LEN_LINE - 3),
            .NR_BE    (8)
        ) data_ram (
            .clk   (clk),
            .addra ({refill_line, axi_cnt[fetch_pkg::LEN_LINE-3:1]}),
            .dina  ({rdata, rdata}),
            .wea   (data_wea[w]),
            .addrb (inst_va_next[3 +: fetch_pkg::LEN_INDEX + fetch_pkg::LEN_LINE - 3]),
            .doutb (cache_data[w])
        );

        bram_dp #(
            .LEN_DATA (fetch_pkg::LEN_TAG),
            .LEN_ADDR (fetch_pkg::LEN_INDEX),
            .NR_BE    (1)
        ) tag_ram (
            .clk   (clk),
            .addra (refill_line),
            .dina  (refill_tag),
            .wea   (tag_wea[w]),
            .addrb (inst_va_next[fetch_pkg::LEN_LINE +: fetch_pkg::LEN_INDEX]),
            .doutb (cache_tag[w])
        );

        assign hit_vec[w] = cache_tag[w] == inst_tag && meta_valid[va_line][w];
    end

    assign cache_hit = |hit_vec;
    assign hit_ok = cache_hit && translation_ok && !uncached;
    // two ways, so the upper hit bit is the way number
    assign hit_way = hit_vec[1];
    assign cache_inst0 = inst_va[2] ? cache_data[hit_way][63:32] : cache_data[hit_way][31:0];
    assign cache_inst1 = cache_data[hit_way][63:32];

    // a redirect during a miss makes the saved result stale
    assign saved_match = inst_va == req_va;

    assign istall = state == IDLE ? (!hit_ok && inst_en) : state != SAVE_RESULT;
    assign inst_ok0 = (state == IDLE ? hit_ok : saved_ok0 && saved_match) && inst_en;
    assign inst_ok1 = state == IDLE && hit_ok && !inst_va[2] && inst_en;
    assign inst_rdata0 = state == IDLE ? cache_inst0 : saved_inst0;
    assign inst_rdata1 = state == IDLE ? cache_inst1 : '0;

    assign itlb_vpn2 = req_va[31:13];
    assign fence_ok = !istall && !stallF;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            itlb_valid <= 1'b0;
            meta_valid <= '{default: '0};
            meta_lru <= '{default: 1'b0};
            inst_tlb_refill <= 1'b0;
            inst_tlb_invalid <= 1'b0;
            saved_ok0 <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            axi_cnt <= '0;
        end else begin
            if (fence_tlb && fence_ok) begin
                itlb_valid <= 1'b0;
            end
            if (fence_i && fence_ok) begin
                meta_valid[fence_line] <= '0;
            end
            case (state)
                IDLE: begin
                    if (inst_en) begin
                        if (!translation_ok) begin
                            req_va <= inst_va;
                            state <= TLB_FILL;
                        end else if (uncached) begin
                            req_va <= inst_va;
                            araddr <= inst_pa;
                            arlen <= 8'd0;
                            arsize <= 3'd2;
                            arvalid <= 1'b1;
                            state <= UNCACHED;
                        end else if (!cache_hit) begin
                            araddr <= {inst_pa[31:fetch_pkg::LEN_LINE], {fetch_pkg::LEN_LINE{1'b0}}};
                            arlen <= 8'(fetch_pkg::NR_WORDS - 1);
                            arsize <= 3'd2;
                            arvalid <= 1'b1;
                            refill_line <= va_line;
                            refill_tag <= inst_tag;
                            refill_way <= meta_lru[va_line];
                            axi_cnt <= '0;
                            state <= REFILL;
                        end else if (!stallF) begin
                            meta_lru[va_line] <= ~hit_way;
                        end
                    end
                end
                TLB_FILL: begin
                    // jtlb answers combinationally on req_va
                    if (itlb_found && (req_va[12] ? itlb_entry.v1 : itlb_entry.v0)) begin
                        itlb_vpn <= req_va[31:12];
                        itlb_ppn <= req_va[12] ? itlb_entry.pfn1 : itlb_entry.pfn0;
                        itlb_uncached <= req_va[12] ? !itlb_entry.c1 : !itlb_entry.c0;
                        itlb_valid <= 1'b1;
                        state <= IDLE;
                    end else begin
                        inst_tlb_refill <= !itlb_found;
                        inst_tlb_invalid <= itlb_found;
                        saved_inst0 <= '0;
                        saved_ok0 <= 1'b1;
                        state <= SAVE_RESULT;
                    end
                end
                UNCACHED: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready <= 1'b1;
                        end
                    end else if (rvalid && rready) begin
                        saved_inst0 <= rdata;
                        saved_ok0 <= 1'b1;
                        rready <= 1'b0;
                        state <= SAVE_RESULT;
                    end
                end
                REFILL: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready <= 1'b1;
                        end
                    end else if (beat) begin
                        axi_cnt <= axi_cnt + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            meta_valid[refill_line][refill_way] <= 1'b1;
                            meta_lru[refill_line] <= ~refill_way;
                        end
                    end else if (!rready) begin
                        // last beat written, ram output valid from here
                        state <= IDLE;
                    end
                end
                SAVE_RESULT: begin
                    if (!stallF) begin
                        inst_tlb_refill <= 1'b0;
                        inst_tlb_invalid <= 1'b0;
                        saved_ok0 <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/fetch_reg.sv ====
module fetch_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   istall,
    input  logic                   redirect,
    input  fetch_pkg::vaddr_t      inst_va,
    input  logic                   inst_ok0,
    input  logic                   inst_ok1,
    input  fetch_pkg::inst_t       inst_rdata0,
    input  fetch_pkg::inst_t       inst_rdata1,
    input  logic                   inst_tlb_refill,
    input  logic                   inst_tlb_invalid,
    output logic                   out_valid,
    output fetch_pkg::vaddr_t      out_pc,
    output fetch_pkg::inst_t       out_inst0,
    output fetch_pkg::inst_t       out_inst1,
    output logic                   out_two,
    output fetch_pkg::fetch_exc_t  out_exc
);

    logic accept;
    fetch_pkg::fetch_exc_t exc;

    assign accept = inst_ok0 && !istall && !stall;

    always_comb begin
        if (inst_tlb_refill) begin
            exc = fetch_pkg::EXC_TLB_REFILL;
        end else if (inst_tlb_invalid) begin
            exc = fetch_pkg::EXC_TLB_INVALID;
        end else begin
            exc = fetch_pkg::EXC_NONE;
        end
    end

    // redirect drops the packet fetched on the wrong path
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !redirect) begin
            out_pc <= inst_va;
            out_inst0 <= inst_rdata0;
            out_inst1 <= inst_rdata1;
            // an exception packet carries one slot only
            out_two <= inst_ok1 && exc == fetch_pkg::EXC_NONE;
            out_exc <= exc;
        end
    end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   redirect,
    input  fetch_pkg::vaddr_t      redirect_pc,
    input  logic                   fence_i,
    input  fetch_pkg::vaddr_t      fence_addr,
    input  logic                   fence_tlb,
    input  logic                   tlb_we,
    input  fetch_pkg::tlb_idx_t    tlb_windex,
    input  fetch_pkg::tlb_entry    tlb_wentry,
    output fetch_pkg::paddr_t      araddr,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [31:0]            rdata,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output logic                   out_valid,
    output fetch_pkg::vaddr_t      out_pc,
    output fetch_pkg::inst_t       out_inst0,
    output fetch_pkg::inst_t       out_inst1,
    output logic                   out_two,
    output fetch_pkg::fetch_exc_t  out_exc
);

    logic inst_en;
    fetch_pkg::vaddr_t inst_va;
    fetch_pkg::vaddr_t inst_va_next;
    logic istall;
    logic inst_ok0;
    logic inst_ok1;
    fetch_pkg::inst_t inst_rdata0;
    fetch_pkg::inst_t inst_rdata1;
    logic inst_tlb_refill;
    logic inst_tlb_invalid;
    fetch_pkg::vpn2_t itlb_vpn2;
    logic itlb_found;
    fetch_pkg::tlb_entry itlb_entry;

    fetch_pc fetch_pc_i (.*);

    i_cache i_cache_i (
        .stallF (stall),
        .*
    );

    jtlb jtlb_i (
        .clk    (clk),
        .rst    (rst),
        .we     (tlb_we),
        .windex (tlb_windex),
        .wentry (tlb_wentry),
        .vpn2   (itlb_vpn2),
        .found  (itlb_found),
        .entry  (itlb_entry)
    );

    fetch_reg fetch_reg_i (.*);

endmodule

// ==== verif/axi_mem_model.sv ====
module axi_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::paddr_t   araddr,
    input  logic [7:0]          arlen,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,
    output int                  bursts
);

    typedef enum logic {
        ADDR,
        DATA
    } mem_state_t;

    mem_state_t state;
    int seed = 32'hbebde496;
    int delay;
    int beat;
    fetch_pkg::paddr_t addr;
    logic [7:0] len;

    // ready and valid only rise when the other side is already waiting,
    // so every pulse is one transfer at the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            state <= ADDR;
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rdata <= '0;
            bursts <= 0;
            delay <= 0;
            beat <= 0;
        end else begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            case (state)
                ADDR: begin
                    if (arvalid) begin
                        if (delay == 0) begin
                            arready <= 1'b1;
                            addr <= araddr;
                            len <= arlen;
                            bursts <= bursts + 1;
                            beat <= 0;
                            delay <= $unsigned($random(seed)) % 3;
                            state <= DATA;
                        end else begin
                            delay <= delay - 1;
                        end
                    end
                end
                DATA: begin
                    if (rready) begin
                        if (delay == 0) begin
                            rvalid <= 1'b1;
                            rdata <= (addr + 32'(beat * 4)) ^ 32'h5a5a_0000;
                            rlast <= beat == int'(len);
                            delay <= $unsigned($random(seed)) % 3;
                            if (beat == int'(len)) begin
                                state <= ADDR;
                            end else begin
                                beat <= beat + 1;
                            end
                        end else begin
                            delay <= delay - 1;
                        end
                    end
                end
                default: begin
                    state <= ADDR;
                end
            endcase
        end
    end

endmodule

// ==== verif/tb_fetch_top.sv ====
module tb_fetch_top;

    logic clk;
    logic rst;
    logic stall;
    logic redirect;
    fetch_pkg::vaddr_t redirect_pc;
    logic fence_i;
    fetch_pkg::vaddr_t fence_addr;
    logic fence_tlb;
    logic tlb_we;
    fetch_pkg::tlb_idx_t tlb_windex;
    fetch_pkg::tlb_entry tlb_wentry;
    fetch_pkg::paddr_t araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    logic out_valid;
    fetch_pkg::vaddr_t out_pc;
    fetch_pkg::inst_t out_inst0;
    fetch_pkg::inst_t out_inst1;
    logic out_two;
    fetch_pkg::fetch_exc_t out_exc;
    int bursts;
    int seed = 32'hbebde496;

    // stimulus table with one row per test
    string row_name [16];
    logic row_redirect [16];
    fetch_pkg::vaddr_t row_pc [16];
    logic row_we [16];
    fetch_pkg::tlb_idx_t row_widx [16];
    fetch_pkg::tlb_entry row_entry [16];
    logic row_fence_i [16];
    logic row_fence_tlb [16];
    logic row_rand_stall [16];
    int row_npkts [16];
    fetch_pkg::fetch_exc_t row_exc [16];
    fetch_pkg::paddr_t row_pbase [16];
    logic row_cached [16];
    int row_bursts [16];
    int nrows;

    fetch_top fetch_top_i (.*);

    axi_mem_model mem_i (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .bursts  (bursts)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory returns each word's own address mixed with a fixed pattern
    function automatic fetch_pkg::inst_t expected_word(fetch_pkg::paddr_t pa);
        return pa ^ 32'h5a5a_0000;
    endfunction

    function automatic fetch_pkg::tlb_entry make_entry(fetch_pkg::vpn2_t vpn2,
            fetch_pkg::pfn_t pfn0, logic c0, logic v0,
            fetch_pkg::pfn_t pfn1, logic c1, logic v1);
        fetch_pkg::tlb_entry e;
        e.vpn2 = vpn2;
        e.pfn0 = pfn0;
        e.c0 = c0;
        e.v0 = v0;
        e.pfn1 = pfn1;
        e.c1 = c1;
        e.v1 = v1;
        return e;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_inst(string name, fetch_pkg::inst_t exp, fetch_pkg::inst_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, fetch_pkg::vaddr_t exp, fetch_pkg::vaddr_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s pc: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_exc(string name, fetch_pkg::fetch_exc_t exp,
            fetch_pkg::fetch_exc_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s exception: expected %s, actual %s",
                name, exp.name(), act.name()));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s count: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s two-word flag: expected %b, actual %b",
                name, exp, act));
        end
    endtask

    task automatic check_size(string name, logic [2:0] exp, logic [2:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAILED %s burst size: expected %0d, actual %0d",
                name, exp, act));
        end
    endtask

    task automatic add_row(string name, logic redir, fetch_pkg::vaddr_t pc,
            logic we, fetch_pkg::tlb_idx_t widx, fetch_pkg::tlb_entry entry,
            logic fi, logic ft, logic rs, int npkts, fetch_pkg::fetch_exc_t exc,
            fetch_pkg::paddr_t pbase, logic cached, int nbursts);
        row_name[nrows] = name;
        row_redirect[nrows] = redir;
        row_pc[nrows] = pc;
        row_we[nrows] = we;
        row_widx[nrows] = widx;
        row_entry[nrows] = entry;
        row_fence_i[nrows] = fi;
        row_fence_tlb[nrows] = ft;
        row_rand_stall[nrows] = rs;
        row_npkts[nrows] = npkts;
        row_exc[nrows] = exc;
        row_pbase[nrows] = pbase;
        row_cached[nrows] = cached;
        row_bursts[nrows] = nbursts;
        nrows++;
    endtask

    // hold stall until the AXI side has been idle for a while
    task automatic settle();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        stall = 1'b1;
        while (quiet < 8) begin
            @(negedge clk);
            quiet = (arvalid || rready) ? 0 : quiet + 1;
            waited++;
            if (waited > 1000) begin
                stop_run("memory traffic did not settle while the fetch was stalled");
            end
        end
    endtask

    task automatic run_row(int r);
        fetch_pkg::vaddr_t exp_pc;
        fetch_pkg::paddr_t pa;
        fetch_pkg::vaddr_t held_pc;
        fetch_pkg::inst_t held_inst;
        logic two;
        logic stall_prev;
        int got;
        int waited;
        int base;
        if (row_redirect[r]) begin
            settle();
        end
        base = bursts;
        stall = 1'b0;
        if (row_redirect[r]) begin
            redirect = 1'b1;
            redirect_pc = row_pc[r];
            fence_i = row_fence_i[r];
            fence_addr = row_pc[r];
            fence_tlb = row_fence_tlb[r];
            tlb_we = row_we[r];
            tlb_windex = row_widx[r];
            tlb_wentry = row_entry[r];
            @(negedge clk);
            redirect = 1'b0;
            fence_i = 1'b0;
            fence_tlb = 1'b0;
            tlb_we = 1'b0;
        end
        stall_prev = 1'b0;
        exp_pc = row_pc[r];
        got = 0;
        waited = 0;
        while (got < row_npkts[r]) begin
            // every beat is one 32-bit word
            if (arvalid) begin
                check_size(row_name[r], 3'd2, arsize);
            end
            if (out_valid && !stall_prev) begin
                check_addr(row_name[r], exp_pc, out_pc);
                check_exc(row_name[r], row_exc[r], out_exc);
                held_pc = exp_pc;
                if (row_exc[r] == fetch_pkg::EXC_NONE) begin
                    pa = row_pbase[r] + (exp_pc - row_pc[r]);
                    two = row_cached[r] && !exp_pc[2];
                    held_inst = expected_word(pa);
                    check_inst(row_name[r], held_inst, out_inst0);
                    check_flag(row_name[r], two, out_two);
                    if (two) begin
                        check_inst(row_name[r], expected_word(pa + 32'd4), out_inst1);
                    end
                end else begin
                    two = 1'b0;
                    check_flag(row_name[r], 1'b0, out_two);
                end
                exp_pc = exp_pc + (two ? 32'd8 : 32'd4);
                got++;
                waited = 0;
            end else if (out_valid && stall_prev && got > 0) begin
                // packet must not move while stalled
                check_addr(row_name[r], held_pc, out_pc);
                if (row_exc[r] == fetch_pkg::EXC_NONE) begin
                    check_inst(row_name[r], held_inst, out_inst0);
                end
            end
            if (got < row_npkts[r]) begin
                waited++;
                if (waited > 300) begin
                    stop_run($sformatf("%s: no fetch packet arrived in time", row_name[r]));
                end
                stall_prev = row_rand_stall[r] ? 1'($random(seed)) : 1'b0;
                stall = stall_prev;
                @(negedge clk);
            end
        end
        check_count(row_name[r], row_bursts[r], bursts - base);
    endtask

    initial begin
        fetch_pkg::tlb_entry none;
        none = '0;
        rst = 1'b1;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        fence_i = 1'b0;
        fence_addr = '0;
        fence_tlb = 1'b0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        nrows = 0;

        // name, redirect, pc, tlb write, fences, random stall, packets,
        // exception, physical base, cached, new bursts
        add_row("boot", 0, fetch_pkg::BOOT_PC, 0, 0, none, 0, 0, 0, 3,
            fetch_pkg::EXC_NONE, 32'h1fc00000, 0, 3);
        add_row("kseg0_line", 1, 32'h80001000, 0, 0, none, 0, 0, 0, 8,
            fetch_pkg::EXC_NONE, 32'h00001000, 1, 1);
        add_row("kseg0_odd", 1, 32'h80002004, 0, 0, none, 0, 0, 0, 4,
            fetch_pkg::EXC_NONE, 32'h00002004, 1, 1);
        add_row("kseg0_rehit", 1, 32'h80001000, 0, 0, none, 0, 0, 0, 4,
            fetch_pkg::EXC_NONE, 32'h00001000, 1, 0);
        add_row("fence_i", 1, 32'h80001000, 0, 0, none, 1, 0, 0, 4,
            fetch_pkg::EXC_NONE, 32'h00001000, 1, 1);
        add_row("mapped_even", 1, 32'h00400000, 1, 0,
            make_entry(19'h200, 20'h01234, 1, 1, 20'h05678, 0, 1), 0, 1, 0, 4,
            fetch_pkg::EXC_NONE, 32'h01234000, 1, 1);
        add_row("mapped_uncached", 1, 32'h00401000, 0, 0, none, 0, 0, 0, 3,
            fetch_pkg::EXC_NONE, 32'h05678000, 0, 3);
        add_row("tlb_refill", 1, 32'h00800000, 0, 0, none, 0, 0, 0, 1,
            fetch_pkg::EXC_TLB_REFILL, 32'h0, 0, 0);
        add_row("tlb_invalid", 1, 32'h00402000, 1, 1,
            make_entry(19'h201, 20'h00777, 1, 0, 20'h00778, 1, 1), 0, 0, 0, 1,
            fetch_pkg::EXC_TLB_INVALID, 32'h0, 0, 0);
        add_row("fence_tlb", 1, 32'h00401000, 1, 0,
            make_entry(19'h200, 20'h01234, 1, 1, 20'h0beef, 1, 1), 0, 1, 0, 4,
            fetch_pkg::EXC_NONE, 32'h0beef000, 1, 1);
        add_row("stall_cached", 1, 32'h80003000, 0, 0, none, 0, 0, 1, 8,
            fetch_pkg::EXC_NONE, 32'h00003000, 1, 1);
        add_row("stall_uncached", 1, 32'ha0004000, 0, 0, none, 0, 0, 1, 4,
            fetch_pkg::EXC_NONE, 32'h00004000, 0, 4);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < nrows; r++) begin
            run_row(r);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/fetch_pkg.sv
src/bram_dp.sv
src/jtlb.sv
src/fetch_pc.sv
src/i_cache.sv
src/fetch_reg.sv
src/fetch_top.sv
verif/axi_mem_model.sv
verif/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_fetch_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
